//--- sim.f
hw/mcu_proto_pkg.sv
hw/mcu_regs_pkg.sv
hw/mcu_spi.sv
hw/mcu_protocol.sv
hw/mem_bridge.sv
hw/mcu_registers.sv
hw/mcu_top.sv
sim/mcu_top_sva.sv
sim/mcu_top_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module mcu_top_tb -o mcu_top_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/mcu_top_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
exit 0

//--- sim/mcu_top_tb.sv
`default_nettype none

module mcu_top_tb;

    logic clk;
    logic reset;
    logic button;
    logic mcu_clk;
    logic mcu_cs;
    logic mcu_mosi;
    logic mcu_miso;
    logic mem_request;
    logic mem_ack;
    logic mem_write;
    mcu_regs_pkg::mem_addr_t mem_address;
    mcu_regs_pkg::mem_word_t mem_wdata;
    mcu_regs_pkg::mem_word_t mem_rdata;
    logic fifo_rx_empty;
    mcu_proto_pkg::byte_t fifo_rx_rdata;
    logic fifo_rx_read;
    logic fifo_tx_full;
    logic fifo_tx_write;
    mcu_proto_pkg::byte_t fifo_tx_wdata;
    mcu_regs_pkg::cfg_flags_t cfg_flags;

    logic [31:0] lcg_state = 32'hcbb1;
    int error_count = 0;
    int check_count = 0;
    int test_count = 0;
    int rx_pops = 0;
    mcu_regs_pkg::mem_word_t mem_model [mcu_regs_pkg::mem_addr_t];
    mcu_regs_pkg::mem_addr_t mem_seen [$];
    mcu_proto_pkg::byte_t rx_fifo [$];
    mcu_proto_pkg::byte_t tx_fifo [$];
    mcu_proto_pkg::byte_t send_q [$];
    mcu_proto_pkg::byte_t reply_q [$];

    mcu_top #(.sync_stages(3)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        assert (got === expected) else begin
            error_count++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic exchange_byte(input mcu_proto_pkg::byte_t tx_byte,
                                 output mcu_proto_pkg::byte_t rx_byte);
        for (int i = 7; i >= 0; i--) begin
            mcu_mosi = tx_byte[i];
            wait_cycles(4);
            rx_byte[i] = mcu_miso; // Mode 0, sampled at the rise.
            mcu_clk = 1'b1;
            wait_cycles(4);
            mcu_clk = 1'b0;
        end
        wait_cycles(8);
    endtask

    task automatic run_frame();
        mcu_proto_pkg::byte_t rx_byte;
        reply_q.delete();
        mcu_cs = 1'b0;
        wait_cycles(8);
        foreach (send_q[i]) begin
            exchange_byte(send_q[i], rx_byte);
            reply_q.push_back(rx_byte);
        end
        mcu_cs = 1'b1;
        wait_cycles(8);
    endtask

    task automatic write_register(input mcu_regs_pkg::reg_addr_t addr,
                                  input mcu_regs_pkg::reg_data_t data);
        send_q = '{8'd2, addr, data[7:0], data[15:8], data[23:16], data[31:24]};
        run_frame();
    endtask

    task automatic read_register(input mcu_regs_pkg::reg_addr_t addr,
                                 output mcu_regs_pkg::reg_data_t data);
        send_q = '{8'd1, addr, 8'd0, 8'd0, 8'd0, 8'd0};
        run_frame();
        data = {reply_q[5], reply_q[4], reply_q[3], reply_q[2]}; // Low byte first.
    endtask

    task automatic write_buffer(input mcu_regs_pkg::reg_addr_t addr,
                                input mcu_regs_pkg::mem_word_t words [$]);
        send_q = '{8'd4, addr};
        foreach (words[k]) begin
            send_q.push_back(words[k][15:8]);
            send_q.push_back(words[k][7:0]);
        end
        run_frame();
    endtask

    task automatic read_buffer(input mcu_regs_pkg::reg_addr_t addr, input int count,
                               output mcu_regs_pkg::mem_word_t words [$]);
        send_q = '{8'd3, addr};
        for (int k = 0; k < 2 * count; k++) send_q.push_back(8'd0);
        run_frame();
        words.delete();
        for (int k = 0; k < count; k++) words.push_back({reply_q[2 + 2 * k], reply_q[3 + 2 * k]});
    endtask

    task automatic wait_transfer_done();
        mcu_regs_pkg::reg_data_t scr;
        int polls;
        polls = 0;
        do begin
            read_register(8'd1, scr);
            polls++;
        end while (scr[3] && polls < 40);
        check_count++;
        assert (!scr[3]) else begin
            error_count++;
            $display("memory transfer still busy after %0d polls at %0t", polls, $time);
        end
    endtask

    task automatic finish_test(input string name);
        test_count++;
        $display("%s finished, %0d errors so far", name, error_count);
    endtask

    initial begin : memory_model
        logic [31:0] rnd;
        forever begin
            @(posedge clk);
            #1;
            if (mem_request && !mem_ack) begin
                rnd = next_rand();
                if (rnd[17:16] != 2'd0) wait_cycles(int'(rnd[17:16])); // 1 to 4 cycles.
                mem_seen.push_back(mem_address);
                if (mem_write) begin
                    mem_model[mem_address] = mem_wdata;
                end else if (mem_model.exists(mem_address)) begin
                    mem_rdata = mem_model[mem_address];
                end else begin
                    mem_rdata = mem_address[31:16] ^ mem_address[15:0];
                end
                mem_ack = 1'b1;
                wait_cycles(1);
                mem_ack = 1'b0;
            end
        end
    end

    initial begin : fifo_model
        forever begin
            @(posedge clk);
            #1;
            if (fifo_rx_read) begin
                rx_pops++;
                if (rx_fifo.size() > 0) fifo_rx_rdata = rx_fifo.pop_front();
            end
            if (fifo_tx_write) tx_fifo.push_back(fifo_tx_wdata);
            fifo_rx_empty = (rx_fifo.size() == 0);
        end
    end

    task automatic test_identify();
        mcu_regs_pkg::reg_data_t data;
        send_q = '{8'd0, 8'd0};
        run_frame();
        check_value("identify reply", 32'(reply_q[1]), 32'h64);
        read_register(8'd4, data);
        check_value("CFG_IDENTIFIER", data, 32'h53437632);
        finish_test("identify");
    endtask

    task automatic test_config();
        mcu_regs_pkg::reg_data_t data;
        logic [31:0] rnd;
        logic [11:0] flags;
        check_value("cfg_flags after reset", 32'(cfg_flags), 32'h001);
        rnd = next_rand();
        flags = rnd[11:0];
        button = 1'b0;
        write_register(8'd3, {20'd0, flags});
        check_value("cfg_flags", 32'(cfg_flags), 32'(flags));
        read_register(8'd3, data);
        check_value("CFG_SCR flags", 32'(data[11:0]), 32'(flags));
        check_value("CFG_SCR button", 32'(data[31]), 32'(!button));
        finish_test("config");
    endtask

    task automatic test_buffer();
        mcu_regs_pkg::mem_word_t words [$];
        mcu_regs_pkg::mem_word_t got [$];
        logic [31:0] rnd;
        for (int k = 0; k < 4; k++) begin
            rnd = next_rand();
            words.push_back(rnd[15:0]);
        end
        write_buffer(8'd5, words);
        read_buffer(8'd5, 4, got);
        for (int k = 0; k < 4; k++) check_value("buffer word", 32'(got[k]), 32'(words[k]));
        read_buffer(8'd6, 2, got); // Second word pair of the block.
        for (int k = 0; k < 2; k++) check_value("buffer word", 32'(got[k]), 32'(words[k + 2]));
        finish_test("buffer");
    endtask

    task automatic test_transfer_out();
        mcu_regs_pkg::mem_word_t words [$];
        mcu_regs_pkg::mem_addr_t addr;
        logic [31:0] rnd;
        for (int k = 0; k < 6; k++) begin
            rnd = next_rand();
            words.push_back(rnd[15:0]);
        end
        write_buffer(8'd0, words);
        mem_seen.delete();
        write_register(8'd0, 32'h0000_1000);
        write_register(8'd1, 32'h0000_00c5); // Start, to memory, 6 words.
        wait_transfer_done();
        check_value("request count", 32'(mem_seen.size()), 32'd6);
        for (int k = 0; k < 6; k++) begin
            addr = 32'h0000_1000 + 32'(2 * k);
            check_value("mem_address", (k < mem_seen.size()) ? mem_seen[k] : 32'hffff_ffff, addr);
            check_value("memory word", mem_model.exists(addr) ? 32'(mem_model[addr]) : 32'hffff_ffff,
                        32'(words[k]));
        end
        finish_test("transfer out");
    endtask

    task automatic test_transfer_in();
        mcu_regs_pkg::mem_word_t words [$];
        mcu_regs_pkg::mem_word_t got [$];
        logic [31:0] rnd;
        for (int k = 0; k < 4; k++) begin
            rnd = next_rand();
            mem_model[32'h0000_2000 + 32'(2 * k)] = rnd[15:0];
            words.push_back(rnd[15:0]);
        end
        write_register(8'd0, 32'h0000_2000);
        write_register(8'd1, 32'h0000_0081); // Start, to buffer, 4 words.
        wait_transfer_done();
        read_buffer(8'd0, 4, got);
        for (int k = 0; k < 4; k++) check_value("buffer word", 32'(got[k]), 32'(words[k]));
        finish_test("transfer in");
    endtask

    task automatic test_usb();
        mcu_regs_pkg::reg_data_t data;
        logic [31:0] rnd;
        fifo_tx_full = 1'b0;
        rx_fifo.delete();
        wait_cycles(2);
        send_q = '{8'd5, 8'd0};
        run_frame();
        check_value("usb status", 32'(reply_q[1]), 32'h02);
        read_register(8'd2, data);
        check_value("USB_SCR", 32'(data[2:1]), 32'b10);
        fifo_tx_full = 1'b1;
        rx_fifo = '{8'h3c, 8'hc3};
        wait_cycles(2);
        send_q = '{8'd5, 8'd0};
        run_frame();
        check_value("usb status", 32'(reply_q[1]), 32'h01);
        read_register(8'd2, data);
        check_value("USB_SCR", 32'(data[2:1]), 32'b01);
        fifo_tx_full = 1'b0;
        rx_pops = 0;
        send_q = '{8'd6, 8'd0};
        run_frame();
        check_value("usb read data", 32'(reply_q[1]), 32'h3c);
        check_value("rx pops", 32'(rx_pops), 32'd1);
        check_value("rx fifo level", 32'(rx_fifo.size()), 32'd1);
        tx_fifo.delete();
        rnd = next_rand();
        send_q = '{8'd7, rnd[7:0]};
        run_frame();
        check_value("tx fifo level", 32'(tx_fifo.size()), 32'd1);
        check_value("tx fifo data", (tx_fifo.size() > 0) ? 32'(tx_fifo[0]) : 32'hffff_ffff,
                    32'(rnd[7:0]));
        finish_test("usb");
    endtask

    initial begin
        reset = 1'b1;
        button = 1'b1;
        mcu_clk = 1'b0;
        mcu_cs = 1'b1;
        mcu_mosi = 1'b0;
        mem_ack = 1'b0;
        mem_rdata = 16'h0000;
        fifo_rx_empty = 1'b1;
        fifo_rx_rdata = 8'h00;
        fifo_tx_full = 1'b0;
        wait_cycles(3);
        reset = 1'b0;
        wait_cycles(4);
        test_config();
        test_identify();
        test_buffer();
        test_transfer_out();
        test_transfer_in();
        test_usb();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/mcu_top_sva.sv
`default_nettype none

module mcu_top_sva (
    input wire logic clk,
    input wire logic reset,
    input wire logic mem_request,
    input wire logic mem_ack,
    input wire logic mem_write,
    input wire mcu_regs_pkg::mem_addr_t mem_address,
    input wire logic data_ready
);

    assert property (@(posedge clk) disable iff (reset)
        mem_request && !mem_ack |=> mem_request)
        else $error("mem_request dropped before mem_ack");

    assert property (@(posedge clk) disable iff (reset)
        mem_request && !mem_ack |=> $stable(mem_address) && $stable(mem_write))
        else $error("memory address or direction changed during a request");

    assert property (@(posedge clk) disable iff (reset)
        data_ready |=> !data_ready)
        else $error("data_ready high on two cycles in a row");

endmodule

bind mem_bridge mcu_top_sva i_bus_sva (
    .clk(clk), .reset(reset), .mem_request(mem_request), .mem_ack(mem_ack),
    .mem_write(mem_write), .mem_address(mem_address), .data_ready(1'b0)
);

bind mcu_spi mcu_top_sva i_spi_sva (
    .clk(clk), .reset(reset), .mem_request(1'b0), .mem_ack(1'b0),
    .mem_write(1'b0), .mem_address(32'd0), .data_ready(data_ready)
);

`default_nettype wire

//--- hw/mcu_top.sv
`default_nettype none

module mcu_top #(
    parameter int sync_stages = 3
) (
    input wire logic clk,
    input wire logic reset,
    input wire logic button,
    input wire logic mcu_clk,
    input wire logic mcu_cs,
    input wire logic mcu_mosi,
    output logic mcu_miso,
    output logic mem_request,
    input wire logic mem_ack,
    output logic mem_write,
    output mcu_regs_pkg::mem_addr_t mem_address,
    output mcu_regs_pkg::mem_word_t mem_wdata,
    input wire mcu_regs_pkg::mem_word_t mem_rdata,
    input wire logic fifo_rx_empty,
    input wire mcu_proto_pkg::byte_t fifo_rx_rdata,
    output logic fifo_rx_read,
    input wire logic fifo_tx_full,
    output logic fifo_tx_write,
    output mcu_proto_pkg::byte_t fifo_tx_wdata,
    output mcu_regs_pkg::cfg_flags_t cfg_flags
);

    logic frame_start;
    logic data_ready;
    mcu_proto_pkg::byte_t rx_data;
    mcu_proto_pkg::byte_t tx_data;
    logic reg_read;
    logic reg_write;
    mcu_regs_pkg::reg_addr_t reg_address;
    mcu_regs_pkg::reg_data_t reg_wdata;
    mcu_regs_pkg::reg_data_t reg_rdata;
    logic buf_read;
    logic buf_write;
    mcu_regs_pkg::buf_index_t buf_index;
    mcu_regs_pkg::mem_word_t buf_wdata;
    mcu_regs_pkg::mem_word_t buf_rdata;
    logic mem_start;
    logic mem_stop;
    logic mem_direction;
    mcu_regs_pkg::buf_index_t mem_length;
    mcu_regs_pkg::mem_addr_t mem_base;
    logic mem_busy;

    mcu_spi i_spi (
        .clk         (clk),
        .reset       (reset),
        .mcu_clk     (mcu_clk),
        .mcu_cs      (mcu_cs),
        .mcu_mosi    (mcu_mosi),
        .mcu_miso    (mcu_miso),
        .frame_start (frame_start),
        .data_ready  (data_ready),
        .rx_data     (rx_data),
        .tx_data     (tx_data)
    );

    mcu_protocol i_protocol (
        .clk           (clk),
        .reset         (reset),
        .frame_start   (frame_start),
        .data_ready    (data_ready),
        .rx_data       (rx_data),
        .tx_data       (tx_data),
        .reg_read      (reg_read),
        .reg_write     (reg_write),
        .reg_address   (reg_address),
        .reg_wdata     (reg_wdata),
        .reg_rdata     (reg_rdata),
        .buf_read      (buf_read),
        .buf_write     (buf_write),
        .buf_index     (buf_index),
        .buf_wdata     (buf_wdata),
        .buf_rdata     (buf_rdata),
        .fifo_rx_empty (fifo_rx_empty),
        .fifo_rx_rdata (fifo_rx_rdata),
        .fifo_rx_read  (fifo_rx_read),
        .fifo_tx_full  (fifo_tx_full),
        .fifo_tx_write (fifo_tx_write),
        .fifo_tx_wdata (fifo_tx_wdata)
    );

    mcu_registers #(
        .sync_stages (sync_stages)
    ) i_registers (
        .clk           (clk),
        .reset         (reset),
        .button        (button),
        .reg_read      (reg_read),
        .reg_write     (reg_write),
        .reg_address   (reg_address),
        .reg_wdata     (reg_wdata),
        .reg_rdata     (reg_rdata),
        .cfg_flags     (cfg_flags),
        .mem_start     (mem_start),
        .mem_stop      (mem_stop),
        .mem_direction (mem_direction),
        .mem_length    (mem_length),
        .mem_base      (mem_base),
        .mem_busy      (mem_busy),
        .fifo_rx_empty (fifo_rx_empty),
        .fifo_tx_full  (fifo_tx_full)
    );

    mem_bridge i_bridge (
        .clk           (clk),
        .reset         (reset),
        .buf_read      (buf_read),
        .buf_write     (buf_write),
        .buf_index     (buf_index),
        .buf_wdata     (buf_wdata),
        .buf_rdata     (buf_rdata),
        .mem_start     (mem_start),
        .mem_stop      (mem_stop),
        .mem_direction (mem_direction),
        .mem_length    (mem_length),
        .mem_base      (mem_base),
        .mem_busy      (mem_busy),
        .mem_request   (mem_request),
        .mem_ack       (mem_ack),
        .mem_write     (mem_write),
        .mem_address   (mem_address),
        .mem_wdata     (mem_wdata),
        .mem_rdata     (mem_rdata)
    );

endmodule

`default_nettype wire

//--- hw/mcu_registers.sv
`default_nettype none

module mcu_registers #(
    parameter int sync_stages = 3
) (
    input wire logic clk,
    input wire logic reset,
    input wire logic button,
    input wire logic reg_read,
    input wire logic reg_write,
    input wire mcu_regs_pkg::reg_addr_t reg_address,
    input wire mcu_regs_pkg::reg_data_t reg_wdata,
    output mcu_regs_pkg::reg_data_t reg_rdata,
    output mcu_regs_pkg::cfg_flags_t cfg_flags,
    output logic mem_start,
    output logic mem_stop,
    output logic mem_direction,
    output mcu_regs_pkg::buf_index_t mem_length,
    output mcu_regs_pkg::mem_addr_t mem_base,
    input wire logic mem_busy,
    input wire logic fifo_rx_empty,
    input wire logic fifo_tx_full
);

    logic [sync_stages-1:0] button_ff;

    always_ff @(posedge clk) begin
        button_ff <= {button_ff[sync_stages-2:0], button};
    end

    always_ff @(posedge clk) begin
        if (reg_read) begin
            case (mcu_regs_pkg::reg_address_e'(reg_address))
                mcu_regs_pkg::REG_MEM_ADDRESS: reg_rdata <= mem_base;
                mcu_regs_pkg::REG_MEM_SCR: reg_rdata <= {28'd0, mem_busy, 3'b000};
                mcu_regs_pkg::REG_USB_SCR: reg_rdata <= {29'd0, ~fifo_tx_full, ~fifo_rx_empty, 1'b0};
                mcu_regs_pkg::REG_CFG_SCR: begin
                    reg_rdata <= {~button_ff[sync_stages-1], 19'd0, cfg_flags};
                end
                mcu_regs_pkg::REG_CFG_IDENTIFIER: reg_rdata <= mcu_regs_pkg::cfg_identifier;
                default: reg_rdata <= 32'd0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        mem_start <= 1'b0;
        mem_stop <= 1'b0;

        if (reset) begin
            cfg_flags <= mcu_regs_pkg::cfg_flags_reset;
            mem_direction <= 1'b0;
        end else if (reg_write) begin
            case (mcu_regs_pkg::reg_address_e'(reg_address))
                mcu_regs_pkg::REG_MEM_ADDRESS: begin
                    mem_base <= reg_wdata;
                end
                mcu_regs_pkg::REG_MEM_SCR: begin
                    mem_start <= reg_wdata[0];
                    mem_stop <= reg_wdata[1];
                    mem_direction <= reg_wdata[2];
                    mem_length <= 9'(reg_wdata[14:5] - 10'd1); // Word count minus one.
                end
                mcu_regs_pkg::REG_CFG_SCR: begin
                    cfg_flags <= reg_wdata[11:0];
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/mem_bridge.sv
`default_nettype none

module mem_bridge (
    input wire logic clk,
    input wire logic reset,
    input wire logic buf_read,
    input wire logic buf_write,
    input wire mcu_regs_pkg::buf_index_t buf_index,
    input wire mcu_regs_pkg::mem_word_t buf_wdata,
    output mcu_regs_pkg::mem_word_t buf_rdata,
    input wire logic mem_start,
    input wire logic mem_stop,
    input wire logic mem_direction,
    input wire mcu_regs_pkg::buf_index_t mem_length,
    input wire mcu_regs_pkg::mem_addr_t mem_base,
    output logic mem_busy,
    output logic mem_request,
    input wire logic mem_ack,
    output logic mem_write,
    output mcu_regs_pkg::mem_addr_t mem_address,
    output mcu_regs_pkg::mem_word_t mem_wdata,
    input wire mcu_regs_pkg::mem_word_t mem_rdata
);

    mcu_regs_pkg::mem_word_t buffer [0:511];
    mcu_regs_pkg::buf_index_t transfer_count;
    logic stop_pending;

    always_ff @(posedge clk) begin
        if (buf_write) begin
            buffer[buf_index] <= buf_wdata;
        end
        if (mem_busy && mem_ack && !mem_write) begin
            buffer[transfer_count] <= mem_rdata;
        end
        if (buf_read) begin
            buf_rdata <= buffer[buf_index];
        end
        if (mem_busy && !mem_request) begin
            mem_wdata <= buffer[transfer_count]; // Next outgoing word.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_busy <= 1'b0;
            mem_request <= 1'b0;
            mem_write <= 1'b0;
            stop_pending <= 1'b0;
            transfer_count <= 9'd0;
        end else begin
            if (mem_stop) begin
                stop_pending <= mem_busy;
            end else if (mem_start && !mem_busy) begin
                mem_write <= mem_direction;
                mem_address <= mem_base;
                mem_busy <= 1'b1;
                transfer_count <= 9'd0;
            end

            if (mem_busy) begin
                if (!mem_request) begin
                    mem_request <= 1'b1;
                end
                if (mem_ack) begin
                    mem_request <= 1'b0;
                    mem_address <= mem_address + 32'd2;
                    transfer_count <= transfer_count + 9'd1;
                    if ((transfer_count == mem_length) || stop_pending) begin
                        mem_busy <= 1'b0;
                        stop_pending <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/mcu_protocol.sv
`default_nettype none

module mcu_protocol (
    input wire logic clk,
    input wire logic reset,
    input wire logic frame_start,
    input wire logic data_ready,
    input wire mcu_proto_pkg::byte_t rx_data,
    output mcu_proto_pkg::byte_t tx_data,
    output logic reg_read,
    output logic reg_write,
    output mcu_regs_pkg::reg_addr_t reg_address,
    output mcu_regs_pkg::reg_data_t reg_wdata,
    input wire mcu_regs_pkg::reg_data_t reg_rdata,
    output logic buf_read,
    output logic buf_write,
    output mcu_regs_pkg::buf_index_t buf_index,
    output mcu_regs_pkg::mem_word_t buf_wdata,
    input wire mcu_regs_pkg::mem_word_t buf_rdata,
    input wire logic fifo_rx_empty,
    input wire mcu_proto_pkg::byte_t fifo_rx_rdata,
    output logic fifo_rx_read,
    input wire logic fifo_tx_full,
    output logic fifo_tx_write,
    output mcu_proto_pkg::byte_t fifo_tx_wdata
);

    mcu_proto_pkg::phase_e phase;
    mcu_proto_pkg::cmd_e cmd;
    logic [1:0] counter;
    mcu_regs_pkg::reg_addr_t address;
    logic word_select;

    assign reg_address = address;
    assign buf_index = {address, word_select};

    always_ff @(posedge clk) begin
        reg_read <= 1'b0;
        reg_write <= 1'b0;
        buf_read <= 1'b0;
        buf_write <= 1'b0;
        fifo_rx_read <= 1'b0;
        fifo_tx_write <= 1'b0;

        if (reset) begin
            phase <= mcu_proto_pkg::PHASE_NOP;
            cmd <= mcu_proto_pkg::CMD_IDENTIFY;
            counter <= 2'd0;
            address <= 8'd0;
            word_select <= 1'b0;
        end else begin
            if (frame_start) begin
                counter <= 2'd0;
                phase <= mcu_proto_pkg::PHASE_CMD;
            end

            if (reg_read || reg_write || (word_select && (buf_read || buf_write))) begin
                address <= address + 8'd1;
            end

            if (data_ready) begin
                case (phase)
                    mcu_proto_pkg::PHASE_CMD: begin
                        cmd <= mcu_proto_pkg::cmd_e'(rx_data);
                        phase <= mcu_proto_pkg::PHASE_ADDRESS;
                        if (rx_data == mcu_proto_pkg::CMD_USB_STATUS) begin
                            phase <= mcu_proto_pkg::PHASE_NOP;
                        end
                        if (rx_data == mcu_proto_pkg::CMD_USB_READ) begin
                            fifo_rx_read <= 1'b1;
                            phase <= mcu_proto_pkg::PHASE_DATA;
                        end
                        if (rx_data == mcu_proto_pkg::CMD_USB_WRITE) begin
                            phase <= mcu_proto_pkg::PHASE_DATA;
                        end
                    end

                    mcu_proto_pkg::PHASE_ADDRESS: begin
                        address <= rx_data;
                        phase <= mcu_proto_pkg::PHASE_DATA;
                        reg_read <= (cmd == mcu_proto_pkg::CMD_REG_READ);
                        if (cmd == mcu_proto_pkg::CMD_MEM_READ) begin
                            buf_read <= 1'b1;
                            word_select <= 1'b0;
                        end
                    end

                    mcu_proto_pkg::PHASE_DATA: begin
                        counter <= counter + 2'd1;
                        case (cmd)
                            mcu_proto_pkg::CMD_REG_READ: begin
                                reg_read <= (counter == 2'd3);
                            end
                            mcu_proto_pkg::CMD_REG_WRITE: begin
                                reg_wdata[counter*8 +: 8] <= rx_data; // Low byte first.
                                reg_write <= (counter == 2'd3);
                            end
                            mcu_proto_pkg::CMD_MEM_READ: begin
                                if (counter[0]) begin
                                    buf_read <= 1'b1;
                                    word_select <= ~word_select;
                                end
                            end
                            mcu_proto_pkg::CMD_MEM_WRITE: begin
                                if (counter[0]) begin
                                    buf_wdata[7:0] <= rx_data;
                                    buf_write <= 1'b1;
                                    word_select <= counter[1];
                                end else begin
                                    buf_wdata[15:8] <= rx_data; // High byte first.
                                end
                            end
                            mcu_proto_pkg::CMD_USB_READ: begin
                                phase <= mcu_proto_pkg::PHASE_NOP;
                            end
                            mcu_proto_pkg::CMD_USB_WRITE: begin
                                fifo_tx_write <= 1'b1;
                                fifo_tx_wdata <= rx_data;
                                phase <= mcu_proto_pkg::PHASE_NOP;
                            end
                            default: begin
                            end
                        endcase
                    end

                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        case (cmd)
            mcu_proto_pkg::CMD_IDENTIFY: tx_data = mcu_proto_pkg::fpga_id;
            mcu_proto_pkg::CMD_REG_READ: tx_data = reg_rdata[counter*8 +: 8];
            mcu_proto_pkg::CMD_MEM_READ: tx_data = counter[0] ? buf_rdata[7:0] : buf_rdata[15:8];
            mcu_proto_pkg::CMD_USB_STATUS: tx_data = {6'd0, ~fifo_tx_full, ~fifo_rx_empty};
            mcu_proto_pkg::CMD_USB_READ: tx_data = fifo_rx_rdata;
            default: tx_data = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/mcu_spi.sv
`default_nettype none

module mcu_spi (
    input wire logic clk,
    input wire logic reset,
    input wire logic mcu_clk,
    input wire logic mcu_cs,
    input wire logic mcu_mosi,
    output logic mcu_miso,
    output logic frame_start,
    output logic data_ready,
    output mcu_proto_pkg::byte_t rx_data,
    input wire mcu_proto_pkg::byte_t tx_data
);

    logic [2:0] sclk_ff;
    logic [2:0] cs_ff;
    logic [1:0] mosi_ff;
    logic [2:0] bit_count;
    logic [6:0] rx_shift;
    logic [7:0] tx_shift;
    logic [1:0] load_pipe;
    logic sclk_rise;
    logic sclk_fall;
    logic cs_fall;
    logic selected;

    assign sclk_rise = sclk_ff[1] && !sclk_ff[2];
    assign sclk_fall = !sclk_ff[1] && sclk_ff[2];
    assign cs_fall = !cs_ff[1] && cs_ff[2];
    assign selected = !cs_ff[1];
    assign mcu_miso = tx_shift[7];

    always_ff @(posedge clk) begin
        mosi_ff <= {mosi_ff[0], mcu_mosi};
        if (sclk_rise && selected) begin
            rx_shift <= {rx_shift[5:0], mosi_ff[1]};
            if (bit_count == 3'd7) begin
                rx_data <= {rx_shift, mosi_ff[1]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sclk_ff <= 3'b000;
            cs_ff <= 3'b111; // Idle deselected.
            bit_count <= 3'd0;
            frame_start <= 1'b0;
            data_ready <= 1'b0;
            load_pipe <= 2'b00;
            tx_shift <= 8'h00;
        end else begin
            sclk_ff <= {sclk_ff[1:0], mcu_clk};
            cs_ff <= {cs_ff[1:0], mcu_cs};
            frame_start <= cs_fall;
            data_ready <= sclk_rise && selected && (bit_count == 3'd7);
            load_pipe <= {load_pipe[0], data_ready};

            if (cs_fall) begin
                bit_count <= 3'd0;
            end else if (sclk_rise && selected) begin
                bit_count <= bit_count + 3'd1;
            end

            // No shift on the falling edge that closes a byte.
            if (load_pipe[1] || frame_start) begin
                tx_shift <= tx_data;
            end else if (sclk_fall && selected && (bit_count != 3'd0)) begin
                tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/mcu_regs_pkg.sv
`default_nettype none

package mcu_regs_pkg;

    typedef logic [7:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;
    typedef logic [15:0] mem_word_t;
    typedef logic [8:0] buf_index_t;
    typedef logic [31:0] mem_addr_t;
    typedef logic [11:0] cfg_flags_t;

    typedef enum logic [7:0] {
        REG_MEM_ADDRESS    = 8'd0,
        REG_MEM_SCR        = 8'd1,
        REG_USB_SCR        = 8'd2,
        REG_CFG_SCR        = 8'd3,
        REG_CFG_IDENTIFIER = 8'd4
    } reg_address_e;

    localparam cfg_flags_t cfg_flags_reset = 12'h001; // Bootloader enabled.

    localparam reg_data_t cfg_identifier = 32'h53437632;

endpackage

`default_nettype wire

//--- hw/mcu_proto_pkg.sv
`default_nettype none

package mcu_proto_pkg;

    typedef logic [7:0] byte_t;

    typedef enum logic [7:0] {
        CMD_IDENTIFY   = 8'd0,
        CMD_REG_READ,
        CMD_REG_WRITE,
        CMD_MEM_READ,
        CMD_MEM_WRITE,
        CMD_USB_STATUS,
        CMD_USB_READ,
        CMD_USB_WRITE  = 8'd7
    } cmd_e;

    typedef enum logic [1:0] {
        PHASE_CMD,
        PHASE_ADDRESS,
        PHASE_DATA,
        PHASE_NOP
    } phase_e;

    localparam byte_t fpga_id = 8'h64;

endpackage

`default_nettype wire
